// ==== src/cache_geom_pkg.sv ====
package cache_geom_pkg;

	localparam int TAG_W   = 8;                           // Tag bits above the index
	localparam int INDEX_W = 6;                           // 64 lines per cache
	localparam int WORD_W  = 2;                           // Four words per line
	localparam int ADDR_W  = TAG_W + INDEX_W + WORD_W;    // 16-bit word address
	localparam int LINES   = 1 << INDEX_W;

	// Lookup view split into the three cache fields
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		logic [WORD_W-1:0]  word;
	} addr_fields_t;

	// Memory view as line number plus word offset
	typedef struct packed {
		logic [TAG_W+INDEX_W-1:0] line_adr;
		logic [WORD_W-1:0]        word;
	} addr_line_t;

	typedef union packed {
		addr_fields_t f;                                  // Tag, index, word
		addr_line_t   l;                                  // Line address, word
	} cache_addr_u;

endpackage

// ==== src/mem_bus_pkg.sv ====
package mem_bus_pkg;

	localparam int WORD_BITS  = 16;                       // Processor word
	localparam int LINE_WORDS = 4;
	localparam int LINE_BITS  = WORD_BITS * LINE_WORDS;   // One bus transfer
	localparam int LINE_ADR_W = 14;                       // Line number on the bus
	localparam int MEM_LINES  = 1 << LINE_ADR_W;

	// Word 0 sits in bits 15:0
	typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;

endpackage

// ==== src/cache_if.sv ====
interface cache_array_if import cache_geom_pkg::*, mem_bus_pkg::*; ();

	logic                 hit;                            // Valid and tag match
	logic                 dirty;                          // Indexed line needs write-back
	logic [TAG_W-1:0]     victim_tag;                     // Tag now held at the index
	line_t                line;                           // Whole indexed line
	logic [WORD_BITS-1:0] rword;                          // Addressed word of that line
	cache_addr_u          addr;                           // Request address, both views
	logic                 we;                             // Line write strobe
	line_t                wline;
	logic                 wdirty;                         // Dirty bit stored with wline

	modport array (
		input  addr, we, wline, wdirty,
		output hit, dirty, victim_tag, line, rword
	);

	// Controller reads the address that the top level drives
	modport ctrl (
		input  hit, dirty, victim_tag, line, rword, addr,
		output we, wline, wdirty
	);

endinterface

interface line_bus_if import mem_bus_pkg::*; ();

	logic                  cyc;
	logic                  stb;
	logic                  we;                            // 1 = line write
	logic [LINE_ADR_W-1:0] adr;                           // Line number
	line_t                 dat_w;
	line_t                 dat_r;
	logic                  ack;                           // One cycle per transfer

	modport master (output cyc, stb, we, adr, dat_w, input  dat_r, ack);
	modport slave  (input  cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

// ==== src/cache_array.sv ====
module cache_array import cache_geom_pkg::*, mem_bus_pkg::*; (
	input logic          clk,
	input logic          rst_n,
	cache_array_if.array i_port
);

	logic [TAG_W-1:0]   tag_mem [LINES];                  // Stored tag per line
	line_t              line_mem [LINES];                 // Line data
	logic [LINES-1:0]   valid_q;
	logic [LINES-1:0]   dirty_q;
	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0]   req_tag;
	logic [WORD_W-1:0]  req_word;
	logic               tag_eq;

	assign idx      = i_port.addr.f.index;
	assign req_tag  = i_port.addr.f.tag;
	assign req_word = i_port.addr.f.word;

	// Lookup is purely combinational
	assign tag_eq            = (tag_mem[idx] == req_tag);
	assign i_port.hit        = valid_q[idx] & tag_eq;
	assign i_port.dirty      = valid_q[idx] & dirty_q[idx]; // Only a valid line can be dirty
	assign i_port.victim_tag = tag_mem[idx];
	assign i_port.line       = line_mem[idx];
	assign i_port.rword      = line_mem[idx][req_word];     // Word mux

	// Status bits cleared so every line starts invalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (i_port.we) begin
			valid_q[idx] <= 1'b1;                         // Any write leaves the line valid
			dirty_q[idx] <= i_port.wdirty;                // Fill clears, write hit sets
		end
	end

	// Tag and data store
	always_ff @(posedge clk) begin
		if (i_port.we) begin
			tag_mem[idx]  <= req_tag;                     // Same tag on a hit, new tag on fill
			line_mem[idx] <= i_port.wline;
		end
	end

endmodule

// ==== src/cache_controller.sv ====
module cache_controller import cache_geom_pkg::*, mem_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_i_acc,
	input  logic                 i_d_acc,
	input  logic                 i_d_write,
	input  logic [WORD_BITS-1:0] i_d_wdata,
	cache_array_if.ctrl          i_icache,
	cache_array_if.ctrl          i_dcache,
	line_bus_if.master           i_mem,
	output logic                 o_rdy
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WBACK = 2'd1;               // Victim going out
	localparam logic [1:0] ST_FETCH = 2'd2;               // New line coming in

	logic [1:0]            state_q;
	logic [1:0]            state_d;
	logic                  d_miss;
	logic                  i_miss;
	logic                  fill_now;                      // Line on dat_r is valid this edge
	logic [LINE_ADR_W-1:0] victim_adr;
	logic [LINE_ADR_W-1:0] d_line_adr;
	logic [LINE_ADR_W-1:0] i_line_adr;

	// Replace one word of a line
	function automatic line_t merge_word(input line_t base, input logic [WORD_W-1:0] sel,
			input logic [WORD_BITS-1:0] data);
		line_t res;
		res      = base;
		res[sel] = data;
		return res;
	endfunction

	assign d_miss     = i_d_acc & ~i_dcache.hit;
	assign i_miss     = i_i_acc & ~i_icache.hit;
	assign victim_adr = {i_dcache.victim_tag, i_dcache.addr.f.index}; // Where the dirty line lives
	assign d_line_adr = i_dcache.addr.l.line_adr;
	assign i_line_adr = i_icache.addr.l.line_adr;

	assign i_mem.dat_w     = i_dcache.line;               // Only the data side writes back
	assign i_icache.wline  = i_mem.dat_r;                 // Instruction lines come from memory only
	assign i_icache.wdirty = 1'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d         = state_q;
		fill_now        = 1'b0;
		o_rdy           = 1'b0;
		i_mem.cyc       = 1'b0;
		i_mem.stb       = 1'b0;
		i_mem.we        = 1'b0;
		i_mem.adr       = d_line_adr;
		i_icache.we     = 1'b0;
		i_dcache.we     = 1'b0;
		i_dcache.wdirty = 1'b0;
		i_dcache.wline  = i_mem.dat_r;

		case (state_q)
			ST_IDLE: begin
				if (d_miss) begin                         // Data side wins
					i_mem.cyc = 1'b1;
					i_mem.stb = 1'b1;
					if (i_dcache.dirty) begin
						i_mem.we  = 1'b1;
						i_mem.adr = victim_adr;
						state_d   = i_mem.ack ? ST_FETCH : ST_WBACK;
					end else begin
						fill_now = i_mem.ack;             // Back-to-back ack when LATENCY is 1
						state_d  = i_mem.ack ? ST_IDLE : ST_FETCH;
					end
				end else if (i_miss) begin
					i_mem.cyc = 1'b1;
					i_mem.stb = 1'b1;
					i_mem.adr = i_line_adr;
					fill_now  = i_mem.ack;
					state_d   = i_mem.ack ? ST_IDLE : ST_FETCH;
				end else begin
					o_rdy = 1'b1;                         // Every active port hits
					if (i_d_acc && i_d_write) begin
						i_dcache.we     = 1'b1;
						i_dcache.wline  = merge_word(i_dcache.line, i_dcache.addr.f.word,
							i_d_wdata);
						i_dcache.wdirty = 1'b1;
					end
				end
			end
			ST_WBACK: begin
				i_mem.cyc = 1'b1;                         // Hold everything until ack
				i_mem.stb = 1'b1;
				i_mem.we  = 1'b1;
				i_mem.adr = victim_adr;
				if (i_mem.ack)
					state_d = ST_FETCH;
			end
			ST_FETCH: begin
				i_mem.cyc = 1'b1;
				i_mem.stb = 1'b1;
				i_mem.adr = d_miss ? d_line_adr : i_line_adr;
				fill_now  = i_mem.ack;
				if (i_mem.ack)
					state_d = ST_IDLE;                    // Request hits next cycle
			end
			default: state_d = ST_IDLE;
		endcase

		// Data miss still pending means the fill belongs to the data cache
		if (fill_now) begin
			if (d_miss) begin
				i_dcache.we = 1'b1;
				if (i_d_write) begin                      // Write-allocate merge
					i_dcache.wline  = merge_word(i_mem.dat_r, i_dcache.addr.f.word, i_d_wdata);
					i_dcache.wdirty = 1'b1;
				end
			end else begin
				i_icache.we = 1'b1;
			end
		end
	end

endmodule

// ==== src/unified_mem.sv ====
module unified_mem import mem_bus_pkg::*; #(
	parameter int LATENCY = 3                             // Cycles from stb to ack
) (
	input logic       clk,
	input logic       rst_n,
	line_bus_if.slave i_bus
);

	localparam int CNT_W = $clog2(LATENCY + 1);

	line_t            mem [MEM_LINES];
	logic [CNT_W-1:0] cnt_q;                              // Edges seen with stb high
	logic             req;

	// Memory model starts out all zero
	initial begin
		for (int i = 0; i < MEM_LINES; i++)
			mem[i] = '0;
	end

	assign req         = i_bus.cyc & i_bus.stb;
	assign i_bus.ack   = req & (cnt_q == CNT_W'(LATENCY));
	assign i_bus.dat_r = mem[i_bus.adr];                  // Sampled by the master on ack

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt_q <= '0;
		else if (!req)
			cnt_q <= '0;
		else if (i_bus.ack)
			cnt_q <= CNT_W'(1);                           // Ack edge counts for a following transfer
		else
			cnt_q <= cnt_q + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (i_bus.ack && i_bus.we)
			mem[i_bus.adr] <= i_bus.dat_w;                // Write lands on the ack edge
	end

endmodule

// ==== src/split_cache_top.sv ====
module split_cache_top import cache_geom_pkg::*, mem_bus_pkg::*; #(
	parameter int LATENCY = 3
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_i_acc,                 // Instruction fetch request
	input  logic [ADDR_W-1:0]    i_i_addr,
	input  logic                 i_d_acc,                 // Load or store request
	input  logic [ADDR_W-1:0]    i_d_addr,
	input  logic                 i_d_write,
	input  logic [WORD_BITS-1:0] i_d_wdata,
	output logic                 o_rdy,                   // Shared by both ports
	output logic [WORD_BITS-1:0] o_i_rdata,
	output logic [WORD_BITS-1:0] o_d_rdata
);

	cache_array_if icache_if ();
	cache_array_if dcache_if ();
	line_bus_if    mem_bus ();

	assign icache_if.addr = i_i_addr;                     // Raw word address into the union
	assign dcache_if.addr = i_d_addr;
	assign o_i_rdata      = icache_if.rword;
	assign o_d_rdata      = dcache_if.rword;

	cache_array u_icache (.clk(clk), .rst_n(rst_n), .i_port(icache_if));
	cache_array u_dcache (.clk(clk), .rst_n(rst_n), .i_port(dcache_if));

	cache_controller u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_acc   (i_i_acc),
		.i_d_acc   (i_d_acc),
		.i_d_write (i_d_write),
		.i_d_wdata (i_d_wdata),
		.i_icache  (icache_if),
		.i_dcache  (dcache_if),
		.i_mem     (mem_bus),
		.o_rdy     (o_rdy)
	);

	unified_mem #(.LATENCY(LATENCY)) u_mem (.clk(clk), .rst_n(rst_n), .i_bus(mem_bus));

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clk = 1'b0;                                     // Starts low so the first rising edge is at 2 ns
	end

	always #2 o_clk = ~o_clk;                             // 4 ns period

endmodule

// ==== bench/tb_split_cache_assert.sv ====
module tb_split_cache_assert import mem_bus_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  i_d_miss,                // Data port active and missing
	input logic                  i_i_miss,                // Instruction port active and missing
	input logic                  i_cyc,
	input logic                  i_stb,
	input logic                  i_we,
	input logic                  i_ack,
	input logic [LINE_ADR_W-1:0] i_adr,
	input line_t                 i_dat_w
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;                                     // Polled by the testbench top

	// The memory answers only a strobe that was already up at the previous edge
	ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
			i_ack |-> (i_stb && $past(i_stb)))
		else begin
			fail_cnt++;
			$error("ack without a strobe held since the previous cycle");
		end

	// A transfer keeps its request fields until the slave acks
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
			(i_stb && !i_ack) |=> ($stable(i_adr) && $stable(i_we) && $stable(i_dat_w)))
		else begin
			fail_cnt++;
			$error("adr, we or dat_w changed before ack");
		end

	// Bus stays quiet once every active port hits
	idle_no_bus: assert property (@(posedge clk) disable iff (!rst_n)
			i_cyc |-> (i_d_miss || i_i_miss))
		else begin
			fail_cnt++;
			$error("Bus cycle active while every active port hits");
		end

endmodule

bind cache_controller tb_split_cache_assert u_bus_assert (
	.clk      (clk),
	.rst_n    (rst_n),
	.i_d_miss (d_miss),
	.i_i_miss (i_miss),
	.i_cyc    (i_mem.cyc),
	.i_stb    (i_mem.stb),
	.i_we     (i_mem.we),
	.i_ack    (i_mem.ack),
	.i_adr    (i_mem.adr),
	.i_dat_w  (i_mem.dat_w)
);

// ==== bench/tb_split_cache.sv ====
module tb_split_cache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LATENCY = 3;                           // Memory model latency

	logic        clk;
	logic        rst_n;
	logic        i_acc;
	logic [15:0] i_addr;
	logic        d_acc;
	logic [15:0] d_addr;
	logic        d_write;
	logic [15:0] d_wdata;
	logic        rdy;
	logic [15:0] i_rdata;
	logic [15:0] d_rdata;

	logic [15:0] op_q [$];                                // Two ASCII characters per op
	logic [15:0] ia_q [$];
	logic [15:0] da_q [$];
	logic [15:0] wd_q [$];
	logic [15:0] ei_q [$];                                // Expected instruction word
	logic [15:0] ed_q [$];                                // Expected data word
	bit          hit_q [$];                               // o_rdy expected in the first cycle
	int          cycles;
	int          cycle_limit = 100000;                    // Replaced once the file is loaded
	int unsigned seed = 6301;

	tb_clock u_clock (.o_clk(clk));

	split_cache_top #(.LATENCY(LATENCY)) u_split_cache_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_acc   (i_acc),
		.i_i_addr  (i_addr),
		.i_d_acc   (d_acc),
		.i_d_addr  (d_addr),
		.i_d_write (d_write),
		.i_d_wdata (d_wdata),
		.o_rdy     (rdy),
		.o_i_rdata (i_rdata),
		.o_d_rdata (d_rdata)
	);

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;            // Classic LCG constants
	endfunction

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Reads one operation per line and skips lines starting with #
	task automatic load_ops();
		int          fd;
		int          code;
		int          h;
		string       line;
		logic [15:0] op;
		logic [15:0] ia;
		logic [15:0] da;
		logic [15:0] wd;
		logic [15:0] ei;
		logic [15:0] ed;
		fd = $fopen("bench/cache_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file bench/cache_input.txt");
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			code = $sscanf(line, "%s %h %h %h %h %h %d", op, ia, da, wd, ei, ed, h);
			if (code != 7) begin
				$display("Malformed line in the stimulus file: %s", line);
				abort_run();
			end
			op_q.push_back(op);
			ia_q.push_back(ia);
			da_q.push_back(da);
			wd_q.push_back(wd);
			ei_q.push_back(ei);
			ed_q.push_back(ed);
			hit_q.push_back(h != 0);
		end
		$fclose(fd);
	endtask

	task automatic drop_requests();
		i_acc   <= 1'b0;
		d_acc   <= 1'b0;
		d_write <= 1'b0;
	endtask

	// Apply one request, hold it until o_rdy, then check
	task automatic run_op(input int k);
		int   waits;
		logic use_i;
		logic read_d;
		use_i  = (op_q[k] == "IR") || (op_q[k] == "ID");
		read_d = (op_q[k] == "DR") || (op_q[k] == "ID");
		@(posedge clk);
		i_acc   <= use_i;
		i_addr  <= ia_q[k];
		d_acc   <= (op_q[k] != "IR");                     // DR, DW and ID use the data port
		d_addr  <= da_q[k];
		d_write <= (op_q[k] == "DW");
		d_wdata <= wd_q[k];
		waits = 0;
		@(negedge clk);                                   // o_rdy settled mid-cycle
		while (!rdy) begin
			waits++;
			@(negedge clk);
		end
		assert ((waits == 0) == hit_q[k])
			else begin
				$display("Operation %0d: o_rdy came after %0d wait cycles, hit expected %0d",
					k, waits, hit_q[k]);
				abort_run();
			end
		if (use_i)
			assert (i_rdata == ei_q[k])
				else begin
					$display("FAIL %0t o_i_rdata expected %h got %h", $time, ei_q[k], i_rdata);
					abort_run();
				end
		if (read_d)
			assert (d_rdata == ed_q[k])
				else begin
					$display("FAIL %0t o_d_rdata expected %h got %h", $time, ed_q[k], d_rdata);
					abort_run();
				end
	endtask

	// Cycle budget and bound assertion watch
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d clock cycles", cycle_limit);
			abort_run();
		end
		if (u_split_cache_top.u_ctrl.u_bus_assert.fail_cnt != 0) begin
			$display("A bus protocol assertion failed");
			abort_run();
		end
	end

	initial begin
		int gap;
		cycles  <= 0;
		rst_n   <= 1'b0;
		i_acc   <= 1'b0;
		i_addr  <= '0;
		d_acc   <= 1'b0;
		d_addr  <= '0;
		d_write <= 1'b0;
		d_wdata <= '0;
		load_ops();
		cycle_limit = op_q.size() * 2 * (LATENCY + 3) + 20;
		repeat (2) @(posedge clk);                        // Reset held for two cycles
		rst_n <= 1'b1;
		for (int k = 0; k < op_q.size(); k++) begin
			run_op(k);
			seed = lcg_next(seed);
			gap  = int'((seed >> 16) % 4);                // 0 to 3 idle cycles
			if (gap > 0) begin
				@(posedge clk);                           // Edge that takes the request
				drop_requests();
				repeat (gap - 1) @(posedge clk);
			end
		end
		@(posedge clk);
		drop_requests();
		@(negedge clk);
		if (u_split_cache_top.u_ctrl.u_bus_assert.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("A bus protocol assertion failed");
			abort_run();
		end
	end

endmodule

// ==== bench/cache_input.txt ====
# op i_addr d_addr wdata exp_i exp_d hit, all hex except hit
# op is IR, DR, DW or ID; hit 1 means o_rdy in the first cycle of the request
IR 0010 0000 0000 0000 0000 0
IR 0010 0000 0000 0000 0000 1
DW 0000 0120 abcd 0000 0000 0
DR 0000 0120 0000 0000 abcd 1
DW 0000 0122 1234 0000 0000 1
DR 0000 0121 0000 0000 0000 1
DR 0000 0123 0000 0000 0000 1
DR 0000 0122 0000 0000 1234 1
DW 0000 0220 5555 0000 0000 0
DR 0000 0120 0000 0000 abcd 0
IR 0120 0000 0000 abcd 0000 0
ID 0300 0404 0000 0000 0000 0
ID 0300 0404 0000 0000 0000 1
DW 0000 0405 beef 0000 0000 1
ID 0122 0405 0000 1234 beef 1
DR 0000 0220 0000 0000 5555 0
IR 0220 0000 0000 5555 0000 0
DW 0000 1234 0f0f 0000 0000 0
DR 0000 1234 0000 0000 0f0f 1

// ==== vlog.f ====
src/cache_geom_pkg.sv
src/mem_bus_pkg.sv
src/cache_if.sv
src/cache_array.sv
src/cache_controller.sv
src/unified_mem.sv
src/split_cache_top.sv
bench/tb_clock.sv
bench/tb_split_cache_assert.sv
bench/tb_split_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the split cache testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_split_cache
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f vlog.f -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "Test failed, see $LOG"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Test passed"
exit 0
